// File: files.f
+incdir+.
radio_fe_settings_pkg.sv
radio_fe_sample_pkg.sv
fe_setting_decode.sv
rx_fe_correct.sv
tx_fe_correct.sv
radio_port_map.sv
radio_fe_core.sv
tb_radio_fe_core.sv

// File: Makefile
# Verilator build and run for the radio front-end testbench

VERILATOR ?= verilator
TOP       ?= tb_radio_fe_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the simulator status is ignored here, the log decides pass or fail
run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: radio_fe_cases.txt
# W chan addr data | R adc rx0_expected rx1_expected | T tx dac_expected
# all fields hex, sample words are {I, Q}
R 12345678 12345678 12345678
T 7fff8000 7fff8000
W 0 ea 00000010
W 1 eb 0000fff0
R 01000200 00f00200 01000210
R 80057ff8 80007ff8 80057fff
W 0 e0 00000100
W 0 e1 0001ff00
T 7f801000 7fff0f00
T 00108080 01108000
W 1 e0 00001234
W 1 e4 00000003
W 0 e3 00005555
W 0 e8 00007777
W 1 ed 00000003
T 00010002 0101ff02
R 01000200 00f00200 01000210
W 0 ec 00000001
W 1 ec 00000002
R 00300040 00400020 0030ffb0
W 0 ec 00000003
R 00300040 00200000 0030ffb0
W 0 e4 00000001
T 00010002 ff020101
W 0 e4 00000002
T 00010002 01010000
W 0 e4 00000003
T 00010002 00000000

// File: tb_radio_fe_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "radio_fe_consts.svh"

module tb_radio_fe_core;

   import radio_fe_settings_pkg::*;
   import radio_fe_sample_pkg::*;

   localparam int    CLK_HALF   = 4;   // 8 ns period
   localparam int    RST_CYCLES = 10;
   localparam string CASE_FILE  = "radio_fe_cases.txt";

   logic       radio_clk = 1'b0;
   logic       i_rst_n;
   logic       i_set_stb;
   logic       i_set_chan;
   set_addr_t  i_set_addr;
   set_data_t  i_set_data;
   logic       i_adc_stb;
   adc_word_t  i_adc;
   logic       i_tx_stb;
   adc_word_t  i_tx;
   led_t       i_led_ch0;
   led_t       i_led_ch1;
   misc_t      i_misc_ch0;
   logic       o_rx0_stb;
   adc_word_t  o_rx0;
   logic       o_rx1_stb;
   adc_word_t  o_rx1;
   adc_word_t  o_dac;
   led_t       o_radio_led;
   misc_t      o_misc_out;

   led_t       led_exp;      // OR of the led inputs now applied
   misc_t      misc_prev;    // misc word driven before the last edge
   misc_t      misc_now;     // misc word now on the input
   adc_word_t  dac_last;     // dac word expected to be held
   int         cycle_cnt   = 0;
   int         cycle_limit = 1000;
   int         n_cases;

   radio_fe_core i_radio_fe_core (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_set_stb(i_set_stb), .i_set_chan(i_set_chan),
      .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .i_adc_stb(i_adc_stb), .i_adc(i_adc),
      .i_tx_stb(i_tx_stb), .i_tx(i_tx),
      .i_led_ch0(i_led_ch0), .i_led_ch1(i_led_ch1), .i_misc_ch0(i_misc_ch0),
      .o_rx0_stb(o_rx0_stb), .o_rx0(o_rx0),
      .o_rx1_stb(o_rx1_stb), .o_rx1(o_rx1),
      .o_dac(o_dac), .o_radio_led(o_radio_led), .o_misc_out(o_misc_out)
   );

   always #CLK_HALF radio_clk = ~radio_clk;

   // watchdog
   always @(posedge radio_clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) begin
         $display("run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAILED");
         $fatal(1, "watchdog expired");
      end
   end

   //////////////////////////////
   // checks
   //////////////////////////////
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_word(input string what, input adc_word_t got, input adc_word_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         abort_run("sample word mismatch");
      end
   endtask

   task automatic check_led(input string what, input led_t got, input led_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         abort_run("led overlay mismatch");
      end
   endtask

   task automatic check_misc(input string what, input misc_t got, input misc_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         abort_run("misc word mismatch");
      end
   endtask

   // register a write lands in, for the log only
   function automatic fe_reg_e decode_target(input logic chan, input set_addr_t addr);
      fe_reg_e r;
      r = REG_NONE;
      if (addr == set_addr_t'(`RFE_SET_RX_BASE + `RFE_RX_OFS_I_OFF)) r = REG_RX_OFS_I;
      if (addr == set_addr_t'(`RFE_SET_RX_BASE + `RFE_RX_OFS_Q_OFF)) r = REG_RX_OFS_Q;
      if (addr == set_addr_t'(`RFE_SET_RX_BASE + `RFE_RX_MAP_OFF))   r = REG_RX_MAP;
      if (!chan) begin  // tx has one channel
         if (addr == set_addr_t'(`RFE_SET_TX_BASE + `RFE_TX_OFS_I_OFF)) r = REG_TX_OFS_I;
         if (addr == set_addr_t'(`RFE_SET_TX_BASE + `RFE_TX_OFS_Q_OFF)) r = REG_TX_OFS_Q;
         if (addr == set_addr_t'(`RFE_SET_TX_BASE + `RFE_TX_MUX_OFF))   r = REG_TX_MUX;
      end
      return r;
   endfunction

   //////////////////////////////
   // stimulus
   //////////////////////////////
   // one clock with led and misc checks on both edges, then fresh random values
   task automatic next_cycle();
      logic [31:0] rnd;
      @(negedge radio_clk);
      check_led("o_radio_led", o_radio_led, led_exp);    // follows the inputs at once
      check_misc("o_misc_out", o_misc_out, misc_prev);   // new word not taken yet
      @(posedge radio_clk);
      #1;
      misc_prev = misc_now;
      check_misc("o_misc_out", o_misc_out, misc_prev);
      rnd = $urandom;
      i_led_ch0  = rnd[2:0];
      i_led_ch1  = rnd[6:4];
      i_misc_ch0 = $urandom;
      led_exp    = rnd[2:0] | rnd[6:4];
      misc_now   = i_misc_ch0;
   endtask

   task automatic run_write(input logic chan, input set_addr_t addr, input set_data_t data);
      fe_reg_e target;
      target = decode_target(chan, addr);
      $display("%0t ns: write ch%0d addr %0d -> %s", $time, chan, addr, target.name());
      i_set_stb  = 1'b1;
      i_set_chan = chan;
      i_set_addr = addr;
      i_set_data = data;
      next_cycle();
      i_set_stb  = 1'b0;
   endtask

   task automatic send_rx_sample(input adc_word_t adc, input adc_word_t e0, input adc_word_t e1);
      int cycles;
      i_adc_stb = 1'b1;
      i_adc     = adc;
      next_cycle();
      i_adc_stb = 1'b0;
      cycles    = 1;
      while (!o_rx0_stb && cycles < 8) begin
         if (o_rx1_stb) abort_run("rx1 strobe high without rx0 strobe");
         next_cycle();
         cycles++;
      end
      if (!o_rx0_stb) abort_run("rx0 strobe never rose after an adc sample");
      if (cycles != 2) begin
         abort_run($sformatf("rx0 strobe came %0d cycles after the sample, not 2", cycles));
      end
      if (!o_rx1_stb) abort_run("rx1 strobe not aligned with rx0 strobe");
      check_word("o_rx0", o_rx0, e0);
      check_word("o_rx1", o_rx1, e1);
   endtask

   task automatic send_tx_sample(input adc_word_t tx, input adc_word_t exp);
      i_tx_stb = 1'b1;
      i_tx     = tx;
      next_cycle();
      i_tx_stb = 1'b0;
      next_cycle();
      check_word("o_dac before update", o_dac, dac_last);  // still the old word
      next_cycle();
      check_word("o_dac", o_dac, exp);
      dac_last = exp;
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////
   initial begin
      int               fd;
      int               r;
      int               n_lines;
      logic [8*160-1:0] line_buf;
      logic [8*8-1:0]   op;
      logic [31:0]      f0;
      logic [31:0]      f1;
      logic [31:0]      f2;

      i_rst_n    = 1'b0;
      i_set_stb  = 1'b0;
      i_set_chan = 1'b0;
      i_set_addr = '0;
      i_set_data = '0;
      i_adc_stb  = 1'b0;
      i_adc      = '0;
      i_tx_stb   = 1'b0;
      i_tx       = '0;
      i_led_ch0  = '0;
      i_led_ch1  = '0;
      i_misc_ch0 = '0;
      led_exp    = '0;
      misc_prev  = '0;
      misc_now   = '0;
      dac_last   = '0;
      n_cases    = 0;
      n_lines    = 0;
      void'($urandom(32'hcf04b9d6));

      // size the watchdog from the case count
      fd = $fopen(CASE_FILE, "r");
      if (fd == 0) abort_run("cannot open radio_fe_cases.txt");
      while (!$feof(fd)) begin
         if ($fgets(line_buf, fd) != 0) n_lines++;
      end
      $fclose(fd);
      cycle_limit = 20 * n_lines + 200;

      repeat (RST_CYCLES) @(posedge radio_clk);
      #1;
      i_rst_n = 1'b1;
      check_word("o_dac after reset", o_dac, '0);
      check_misc("o_misc_out after reset", o_misc_out, '0);
      if (o_rx0_stb || o_rx1_stb) abort_run("rx strobe high right after reset");

      fd = $fopen(CASE_FILE, "r");
      if (fd == 0) abort_run("cannot reopen radio_fe_cases.txt");
      r = $fscanf(fd, "%s", op);
      while (r == 1) begin
         case (op[7:0])
            "#": void'($fgets(line_buf, fd));  // column notes
            "W": begin
               if ($fscanf(fd, "%h %h %h", f0, f1, f2) != 3) abort_run("bad W line in cases file");
               run_write(f0[0], f1[`RFE_SET_ADDR_W-1:0], f2);
               n_cases++;
            end
            "R": begin
               if ($fscanf(fd, "%h %h %h", f0, f1, f2) != 3) abort_run("bad R line in cases file");
               send_rx_sample(f0, f1, f2);
               n_cases++;
            end
            "T": begin
               if ($fscanf(fd, "%h %h", f0, f1) != 2) abort_run("bad T line in cases file");
               send_tx_sample(f0, f1);
               n_cases++;
            end
            default: abort_run("unknown operation in cases file");
         endcase
         r = $fscanf(fd, "%s", op);
      end
      $fclose(fd);

      // dac must stay put with no strobe
      repeat (4) next_cycle();
      check_word("o_dac idle", o_dac, dac_last);

      if (n_cases == 0) begin
         abort_run("cases file held no operations");
      end else begin
         $display("%0d operations run", n_cases);
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: radio_fe_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "radio_fe_consts.svh"

module radio_fe_core (
   input  wire                               radio_clk,
   input  wire                               i_rst_n,
   // settings bus
   input  wire                               i_set_stb,
   input  wire                               i_set_chan,
   input  radio_fe_settings_pkg::set_addr_t  i_set_addr,
   input  radio_fe_settings_pkg::set_data_t  i_set_data,
   // converters
   input  wire                               i_adc_stb,
   input  radio_fe_sample_pkg::adc_word_t    i_adc,
   input  wire                               i_tx_stb,
   input  radio_fe_sample_pkg::adc_word_t    i_tx,
   // front panel
   input  radio_fe_sample_pkg::led_t         i_led_ch0,
   input  radio_fe_sample_pkg::led_t         i_led_ch1,
   input  radio_fe_sample_pkg::misc_t        i_misc_ch0,
   output logic                              o_rx0_stb,
   output radio_fe_sample_pkg::adc_word_t    o_rx0,
   output logic                              o_rx1_stb,
   output radio_fe_sample_pkg::adc_word_t    o_rx1,
   output radio_fe_sample_pkg::adc_word_t    o_dac,
   output radio_fe_sample_pkg::led_t         o_radio_led,
   output radio_fe_sample_pkg::misc_t        o_misc_out
);

   import radio_fe_sample_pkg::*;

   sample_t  tx_ofs_i, tx_ofs_q;
   tx_mux_e  tx_mux;
   sample_t  rx_ofs_i [`RFE_NUM_RX_CHAN];
   sample_t  rx_ofs_q [`RFE_NUM_RX_CHAN];
   rx_map_e  rx_map   [`RFE_NUM_RX_CHAN];
   logic     rx_stb   [`RFE_NUM_RX_CHAN];
   sample_t  rx_i     [`RFE_NUM_RX_CHAN];
   sample_t  rx_q     [`RFE_NUM_RX_CHAN];
   logic     dac_stb;
   sample_t  dac_i, dac_q;

   fe_setting_decode u_decode (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_set_stb(i_set_stb), .i_set_chan(i_set_chan),
      .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .o_tx_ofs_i(tx_ofs_i), .o_tx_ofs_q(tx_ofs_q), .o_tx_mux(tx_mux),
      .o_rx_ofs_i(rx_ofs_i), .o_rx_ofs_q(rx_ofs_q), .o_rx_map(rx_map)
   );

   // both rx channels see the same adc
   for (genvar c = 0; c < `RFE_NUM_RX_CHAN; c++) begin : g_rx
      rx_fe_correct u_rx (
         .radio_clk(radio_clk), .i_rst_n(i_rst_n),
         .i_adc_stb(i_adc_stb), .i_adc(i_adc),
         .i_ofs_i(rx_ofs_i[c]), .i_ofs_q(rx_ofs_q[c]), .i_map(rx_map[c]),
         .o_rx_stb(rx_stb[c]), .o_rx_i(rx_i[c]), .o_rx_q(rx_q[c])
      );
   end

   tx_fe_correct u_tx (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_tx_stb(i_tx_stb), .i_tx(i_tx),
      .i_ofs_i(tx_ofs_i), .i_ofs_q(tx_ofs_q), .i_mux(tx_mux),
      .o_dac_stb(dac_stb), .o_dac_i(dac_i), .o_dac_q(dac_q)
   );

   radio_port_map u_map (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_dac_stb(dac_stb), .i_dac_i(dac_i), .i_dac_q(dac_q),
      .i_led_ch0(i_led_ch0), .i_led_ch1(i_led_ch1), .i_misc_ch0(i_misc_ch0),
      .o_dac(o_dac), .o_radio_led(o_radio_led), .o_misc_out(o_misc_out)
   );

   assign o_rx0_stb = rx_stb[0];
   assign o_rx0     = {rx_i[0], rx_q[0]};
   assign o_rx1_stb = rx_stb[1];
   assign o_rx1     = {rx_i[1], rx_q[1]};

endmodule

`default_nettype wire

// File: radio_port_map.sv
`timescale 1ns/10ps
`default_nettype none

module radio_port_map (
   input  wire                             radio_clk,
   input  wire                             i_rst_n,
   input  wire                             i_dac_stb,
   input  radio_fe_sample_pkg::sample_t    i_dac_i,
   input  radio_fe_sample_pkg::sample_t    i_dac_q,
   input  radio_fe_sample_pkg::led_t       i_led_ch0,
   input  radio_fe_sample_pkg::led_t       i_led_ch1,
   input  radio_fe_sample_pkg::misc_t      i_misc_ch0,
   output radio_fe_sample_pkg::adc_word_t  o_dac,
   output radio_fe_sample_pkg::led_t       o_radio_led,
   output radio_fe_sample_pkg::misc_t      o_misc_out
);

   //////////////////////////////
   // dac word
   //////////////////////////////
   // held between strobes, converter sees a steady word
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_dac <= '0;
      end else if (i_dac_stb) begin
         o_dac <= {i_dac_i, i_dac_q};  // I high, Q low
      end
   end

   //////////////////////////////
   // leds
   //////////////////////////////
   // both rx channels treated alike, show the overlay
   assign o_radio_led = i_led_ch0 | i_led_ch1;

   //////////////////////////////
   // misc out
   //////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_misc_out <= '0;
      end else begin
         o_misc_out <= i_misc_ch0;  // channel 1 word has no pin
      end
   end

endmodule

`default_nettype wire

// File: tx_fe_correct.sv
`timescale 1ns/10ps
`default_nettype none

module tx_fe_correct (
   input  wire                             radio_clk,
   input  wire                             i_rst_n,
   input  wire                             i_tx_stb,
   input  radio_fe_sample_pkg::adc_word_t  i_tx,
   input  radio_fe_sample_pkg::sample_t    i_ofs_i,
   input  radio_fe_sample_pkg::sample_t    i_ofs_q,
   input  radio_fe_sample_pkg::tx_mux_e    i_mux,
   output logic                            o_dac_stb,
   output radio_fe_sample_pkg::sample_t    o_dac_i,
   output radio_fe_sample_pkg::sample_t    o_dac_q
);

   import radio_fe_sample_pkg::*;

   sample_t   tx_i;
   sample_t   tx_q;
   logic      s1_stb;
   sample_t   s1_i;
   sample_t   s1_q;
   tx_mux_e   s1_mux;

   assign tx_i = sample_t'(i_tx[2*`RFE_SAMPLE_W-1:`RFE_SAMPLE_W]);
   assign tx_q = sample_t'(i_tx[`RFE_SAMPLE_W-1:0]);

   // strobe pipe
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         s1_stb    <= 1'b0;
         o_dac_stb <= 1'b0;
      end else begin
         s1_stb    <= i_tx_stb;
         o_dac_stb <= s1_stb;
      end
   end

   // stage 1, offset added with clamp
   always_ff @(posedge radio_clk) begin
      if (i_tx_stb) begin
         s1_i   <= sat_sample({tx_i[`RFE_SAMPLE_W-1], tx_i} + {i_ofs_i[`RFE_SAMPLE_W-1], i_ofs_i});
         s1_q   <= sat_sample({tx_q[`RFE_SAMPLE_W-1], tx_q} + {i_ofs_q[`RFE_SAMPLE_W-1], i_ofs_q});
         s1_mux <= i_mux;
      end
   end

   // stage 2, output mux
   always_ff @(posedge radio_clk) begin
      if (s1_stb) begin
         case (s1_mux)
            MUX_QI: begin
               o_dac_i <= s1_q;
               o_dac_q <= s1_i;
            end
            MUX_I_ONLY: begin
               o_dac_i <= s1_i;
               o_dac_q <= '0;
            end
            MUX_ZERO: begin
               o_dac_i <= '0;
               o_dac_q <= '0;
            end
            default: begin
               o_dac_i <= s1_i;
               o_dac_q <= s1_q;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rx_fe_correct.sv
`timescale 1ns/10ps
`default_nettype none

module rx_fe_correct (
   input  wire                             radio_clk,
   input  wire                             i_rst_n,
   input  wire                             i_adc_stb,
   input  radio_fe_sample_pkg::adc_word_t  i_adc,
   input  radio_fe_sample_pkg::sample_t    i_ofs_i,
   input  radio_fe_sample_pkg::sample_t    i_ofs_q,
   input  radio_fe_sample_pkg::rx_map_e    i_map,
   output logic                            o_rx_stb,
   output radio_fe_sample_pkg::sample_t    o_rx_i,
   output radio_fe_sample_pkg::sample_t    o_rx_q
);

   import radio_fe_sample_pkg::*;

   sample_t   adc_i;
   sample_t   adc_q;
   logic      s1_stb;
   sample_t   s1_i;
   sample_t   s1_q;
   rx_map_e   s1_map;   // mode travels with its sample

   assign adc_i = sample_t'(i_adc[2*`RFE_SAMPLE_W-1:`RFE_SAMPLE_W]);
   assign adc_q = sample_t'(i_adc[`RFE_SAMPLE_W-1:0]);

   //////////////////////////////
   // stage 1: dc offset
   //////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         s1_stb <= 1'b0;
      end else begin
         s1_stb <= i_adc_stb;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (i_adc_stb) begin
         s1_i   <= sat_sample({adc_i[`RFE_SAMPLE_W-1], adc_i} - {i_ofs_i[`RFE_SAMPLE_W-1], i_ofs_i});
         s1_q   <= sat_sample({adc_q[`RFE_SAMPLE_W-1], adc_q} - {i_ofs_q[`RFE_SAMPLE_W-1], i_ofs_q});
         s1_map <= i_map;
      end
   end

   //////////////////////////////
   // stage 2: iq mapping
   //////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_rx_stb <= 1'b0;
      end else begin
         o_rx_stb <= s1_stb;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (s1_stb) begin
         case (s1_map)
            MAP_SWAP: begin
               o_rx_i <= s1_q;
               o_rx_q <= s1_i;
            end
            MAP_INV_Q: begin
               o_rx_i <= s1_i;
               o_rx_q <= sat_sample(-{s1_q[`RFE_SAMPLE_W-1], s1_q});  // -32768 clamps
            end
            MAP_REAL_ONLY: begin
               o_rx_i <= s1_i;
               o_rx_q <= '0;
            end
            default: begin
               o_rx_i <= s1_i;
               o_rx_q <= s1_q;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: fe_setting_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "radio_fe_consts.svh"

module fe_setting_decode (
   input  wire                                 radio_clk,
   input  wire                                 i_rst_n,
   input  wire                                 i_set_stb,
   input  wire                                 i_set_chan,
   input  radio_fe_settings_pkg::set_addr_t    i_set_addr,
   input  radio_fe_settings_pkg::set_data_t    i_set_data,
   output radio_fe_sample_pkg::sample_t        o_tx_ofs_i,
   output radio_fe_sample_pkg::sample_t        o_tx_ofs_q,
   output radio_fe_sample_pkg::tx_mux_e        o_tx_mux,
   output radio_fe_sample_pkg::sample_t        o_rx_ofs_i [`RFE_NUM_RX_CHAN],
   output radio_fe_sample_pkg::sample_t        o_rx_ofs_q [`RFE_NUM_RX_CHAN],
   output radio_fe_sample_pkg::rx_map_e        o_rx_map [`RFE_NUM_RX_CHAN]
);

   import radio_fe_settings_pkg::*;
   import radio_fe_sample_pkg::*;

   fe_reg_e reg_sel;

   //////////////////////////////
   // address decode
   //////////////////////////////
   always_comb begin
      case (i_set_addr)
         set_addr_t'(`RFE_SET_TX_BASE + `RFE_TX_OFS_I_OFF): reg_sel = REG_TX_OFS_I;
         set_addr_t'(`RFE_SET_TX_BASE + `RFE_TX_OFS_Q_OFF): reg_sel = REG_TX_OFS_Q;
         set_addr_t'(`RFE_SET_TX_BASE + `RFE_TX_MUX_OFF):   reg_sel = REG_TX_MUX;
         set_addr_t'(`RFE_SET_RX_BASE + `RFE_RX_OFS_I_OFF): reg_sel = REG_RX_OFS_I;
         set_addr_t'(`RFE_SET_RX_BASE + `RFE_RX_OFS_Q_OFF): reg_sel = REG_RX_OFS_Q;
         set_addr_t'(`RFE_SET_RX_BASE + `RFE_RX_MAP_OFF):   reg_sel = REG_RX_MAP;
         default:                                           reg_sel = REG_NONE;
      endcase
      // only tx channel 0 exists
      if (i_set_chan && (reg_sel inside {REG_TX_OFS_I, REG_TX_OFS_Q, REG_TX_MUX})) begin
         reg_sel = REG_NONE;
      end
   end

   //////////////////////////////
   // correction registers
   //////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_tx_ofs_i <= '0;
         o_tx_ofs_q <= '0;
         o_tx_mux   <= MUX_IQ;
         for (int c = 0; c < `RFE_NUM_RX_CHAN; c++) begin
            o_rx_ofs_i[c] <= '0;
            o_rx_ofs_q[c] <= '0;
            o_rx_map[c]   <= MAP_NORMAL;
         end
      end else if (i_set_stb) begin
         case (reg_sel)
            REG_TX_OFS_I: o_tx_ofs_i <= sample_t'(i_set_data[`RFE_SAMPLE_W-1:0]);
            REG_TX_OFS_Q: o_tx_ofs_q <= sample_t'(i_set_data[`RFE_SAMPLE_W-1:0]);
            REG_TX_MUX:   o_tx_mux   <= tx_mux_e'(i_set_data[1:0]);  // mode in low bits
            REG_RX_OFS_I: o_rx_ofs_i[i_set_chan] <= sample_t'(i_set_data[`RFE_SAMPLE_W-1:0]);
            REG_RX_OFS_Q: o_rx_ofs_q[i_set_chan] <= sample_t'(i_set_data[`RFE_SAMPLE_W-1:0]);
            REG_RX_MAP:   o_rx_map[i_set_chan]   <= rx_map_e'(i_set_data[1:0]);
            default: ;  // dropped offsets land here
         endcase
      end
   end

endmodule

`default_nettype wire

// File: radio_fe_sample_pkg.sv
`default_nettype none

`include "radio_fe_consts.svh"

package radio_fe_sample_pkg;

   typedef logic signed [`RFE_SAMPLE_W-1:0] sample_t;
   typedef logic [2*`RFE_SAMPLE_W-1:0]      adc_word_t;  // {I, Q}

   // rx I/Q mapping
   typedef enum logic [1:0] {
      MAP_NORMAL,
      MAP_SWAP,
      MAP_INV_Q,
      MAP_REAL_ONLY   // Q forced to zero
   } rx_map_e;

   // tx output mux
   typedef enum logic [1:0] {
      MUX_IQ,
      MUX_QI,
      MUX_I_ONLY,     // Q forced to zero
      MUX_ZERO
   } tx_mux_e;

   typedef logic [2:0]  led_t;   // {RX, TXRX_TX, TXRX_RX}
   typedef logic [31:0] misc_t;

   // clamp a one-bit-wide sum back to the sample range
   function automatic sample_t sat_sample(input logic signed [`RFE_SAMPLE_W:0] v);
      if (v[`RFE_SAMPLE_W] != v[`RFE_SAMPLE_W-1]) begin
         return v[`RFE_SAMPLE_W] ? {1'b1, {(`RFE_SAMPLE_W-1){1'b0}}}
                                 : {1'b0, {(`RFE_SAMPLE_W-1){1'b1}}};
      end
      return v[`RFE_SAMPLE_W-1:0];
   endfunction

endpackage

`default_nettype wire

// File: radio_fe_settings_pkg.sv
`default_nettype none

`include "radio_fe_consts.svh"

package radio_fe_settings_pkg;

   //////////////////////////////
   // settings bus
   //////////////////////////////
   typedef logic [`RFE_SET_ADDR_W-1:0] set_addr_t;
   typedef logic [`RFE_SET_DATA_W-1:0] set_data_t;

   //////////////////////////////
   // decoded register target
   //////////////////////////////
   typedef enum logic [2:0] {
      REG_NONE,       // unmapped or dropped offset
      REG_TX_OFS_I,
      REG_TX_OFS_Q,
      REG_TX_MUX,
      REG_RX_OFS_I,
      REG_RX_OFS_Q,
      REG_RX_MAP
   } fe_reg_e;

endpackage

`default_nettype wire

// File: radio_fe_consts.svh
`ifndef RADIO_FE_CONSTS_SVH
`define RADIO_FE_CONSTS_SVH

//////////////////////////////
// settings register map
//////////////////////////////
`define RFE_SET_TX_BASE      224  // tx front-end block
`define RFE_SET_RX_BASE      232  // rx front-end block

// tx offsets from base, +2 and +3 not kept
`define RFE_TX_OFS_I_OFF     0
`define RFE_TX_OFS_Q_OFF     1
`define RFE_TX_MUX_OFF       4

// rx offsets from base, +0, +1 and +5 not kept
`define RFE_RX_OFS_I_OFF     2
`define RFE_RX_OFS_Q_OFF     3
`define RFE_RX_MAP_OFF       4

//////////////////////////////
// widths
//////////////////////////////
`define RFE_SAMPLE_W         16   // one I or Q half
`define RFE_SET_ADDR_W       8
`define RFE_SET_DATA_W       32
`define RFE_NUM_RX_CHAN      2

`endif
